/* vlog.f */
+incdir+logic
logic/core_pkg.sv
logic/pkt_slot.sv
logic/exu.sv
logic/wbu.sv
logic/core_slice_top.sv
tests/core_slice_chk.sv
tests/core_slice_monitor.sv
tests/core_slice_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_slice_tb
FLIST     ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) logic/core_settings.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/core_slice_tb.sv */
`include "core_settings.svh"

module core_slice_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  localparam int TMO = 100;

  logic             clk;
  logic             rst;
  logic             issue_req;
  issue_pkt_t       issue_pkt;
  logic             issue_ack;
  logic             retire_valid;
  logic [`XLEN-1:0] retire_pc;
  logic [`XLEN-1:0] retire_pc_next;
  logic [4:0]       retire_rd;
  logic [`XLEN-1:0] retire_wd;
  logic             retire_we;
  logic [2:0]       wbu_state;
  logic             ebreak;
  logic [2:0]       test_id;
  logic             done;
  logic             abort = 1'b0;
  int               mon_errors;
  int               acks;
  int               retires;
  int               tb_errors;
  int               seed;

  core_slice_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .issue_req      (issue_req),
    .issue_pkt      (issue_pkt),
    .issue_ack      (issue_ack),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_pc_next (retire_pc_next),
    .retire_rd      (retire_rd),
    .retire_wd      (retire_wd),
    .retire_we      (retire_we),
    .wbu_state      (wbu_state),
    .ebreak         (ebreak)
  );

  core_slice_monitor i_mon (
    .clk            (clk),
    .rst            (rst),
    .issue_ack      (issue_ack),
    .issue_pkt      (issue_pkt),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_pc_next (retire_pc_next),
    .retire_rd      (retire_rd),
    .retire_wd      (retire_wd),
    .retire_we      (retire_we),
    .wbu_state      (wbu_state),
    .ebreak         (ebreak),
    .test_id        (test_id),
    .done           (done),
    .errors         (mon_errors),
    .acks           (acks),
    .retires        (retires)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic print_counts();
    $display("errors: monitor %0d, driver %0d, assertions %0d (acks %0d, retires %0d)",
             mon_errors, tb_errors, i_dut.i_chk.fail_count, acks, retires);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst       = 1'b1;
    issue_req = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // four-phase sender, called 1 ns after an edge
  task automatic send_pkt(input issue_pkt_t p);
    int n;
    issue_pkt = p;
    issue_req = 1'b1;
    n = 0;
    while (!issue_ack && n < TMO) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!issue_ack) begin
      tb_errors++;
      $display("timeout: issue_ack never rose for a pending request");
      abort = 1'b1;
      return;
    end
    issue_req = 1'b0;
    n = 0;
    while (issue_ack && n < TMO) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (issue_ack) begin
      tb_errors++;
      $display("timeout: issue_ack stayed high after req was dropped");
      abort = 1'b1;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (acks != retires && n < TMO) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (acks != retires) begin
      tb_errors++;
      $display("timeout: accepted packets never retired");
      abort = 1'b1;
    end
  endtask

  task automatic idle_gap();
    repeat ({$random(seed)} % 3) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic issue_pkt_t make_pkt(input op_e op);
    issue_pkt_t p;
    p.op      = op;
    p.rd      = 5'($random(seed));
    p.rs1     = 5'($random(seed));
    p.rs2     = 5'($random(seed));
    p.csr_idx = 2'($random(seed));
    p.imm     = $random(seed);
    p.pc      = $random(seed) & 32'hffff_fffc;
    if (op == OP_LUI) p.imm = p.imm & 32'hffff_f000;
    if (op == OP_ECALL && ({$random(seed)} % 4) == 0) p.rs1 = 5'd15;
    return p;
  endfunction

  function automatic op_e alu_op();
    return op_e'(4'({$random(seed)} % 7));
  endfunction

  function automatic op_e any_op();
    return op_e'(4'({$random(seed)} % 10));
  endfunction

  initial begin
    @(posedge abort);
    print_counts();
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    issue_pkt_t p;
    rst       = 1'b1;
    issue_req = 1'b0;
    issue_pkt = '0;
    test_id   = 3'd0;
    done      = 1'b0;
    tb_errors = 0;
    seed      = 71;
    apply_reset();

    test_id = 3'd1;  // back to back, req raised again right away
    repeat (200) send_pkt(make_pkt(alu_op()));

    test_id = 3'd2;
    repeat (60) begin
      if ($random(seed) & 1) send_pkt(make_pkt(OP_CSRRW));
      else send_pkt(make_pkt(alu_op()));
      idle_gap();
    end

    test_id = 3'd3;
    repeat (40) begin
      send_pkt(make_pkt(OP_ECALL));
      p = make_pkt(OP_CSRRW);
      p.csr_idx = `CSR_MCAUSE;
      send_pkt(p);
      p = make_pkt(OP_CSRRW);
      p.csr_idx = `CSR_MEPC;
      send_pkt(p);
      send_pkt(make_pkt(any_op()));
      idle_gap();
    end

    test_id = 3'd4;
    repeat (60) begin
      if ($random(seed) & 1) send_pkt(make_pkt(OP_EBREAK));
      else send_pkt(make_pkt(any_op()));
      idle_gap();
    end
    send_pkt(make_pkt(OP_EBREAK));  // flag left high going into the reset
    drain();

    test_id = 3'd5;
    apply_reset();
    for (int k = 0; k < `NCSR; k++) begin
      p = make_pkt(OP_CSRRW);
      p.csr_idx = 2'(k);
      send_pkt(p);
    end
    repeat (20) send_pkt(make_pkt(any_op()));
    drain();

    done = 1'b1;
    repeat (3) @(posedge clk);
    print_counts();
    if (mon_errors + tb_errors + i_dut.i_chk.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tests/core_slice_monitor.sv */
`include "core_settings.svh"

module core_slice_monitor (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_ack,
  input  core_pkg::issue_pkt_t issue_pkt,
  input  logic                 retire_valid,
  input  logic [`XLEN-1:0]     retire_pc,
  input  logic [`XLEN-1:0]     retire_pc_next,
  input  logic [4:0]           retire_rd,
  input  logic [`XLEN-1:0]     retire_wd,
  input  logic                 retire_we,
  input  logic [2:0]           wbu_state,
  input  logic                 ebreak,
  input  logic [2:0]           test_id,
  input  logic                 done,
  output int                   errors,
  output int                   acks,
  output int                   retires
);
  timeunit 1ns;
  timeprecision 100ps;
  import core_pkg::*;

  issue_pkt_t       pend[$];  // accepted, not yet retired
  logic [`XLEN-1:0] m_regs [`NREG];
  logic [`XLEN-1:0] m_csrs [`NCSR];
  logic             ack_d = 1'b0;
  logic             rst_d = 1'b0;
  logic             done_d = 1'b0;
  logic [2:0]       state_d = 3'd0;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "alu";
      3'd2:    return "csr";
      3'd3:    return "ecall";
      3'd4:    return "ebreak";
      3'd5:    return "mid_reset";
      default: return "reset";
    endcase
  endfunction

  task automatic compare(input string field, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s: expected %h actual %h", test_name(test_id), field, exp, act);
    end
  endtask

  task automatic retire_check();
    issue_pkt_t       p;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] exp_wd;
    logic [`XLEN-1:0] exp_next;
    logic             exp_we;
    logic             exp_cwe;
    if (pend.size() == 0) begin
      errors++;
      $display("retire seen with no accepted packet left to match it");
      return;
    end
    p        = pend.pop_front();
    a        = m_regs[p.rs1];
    b        = m_regs[p.rs2];
    exp_wd   = '0;
    exp_we   = 1'b0;
    exp_cwe  = 1'b0;
    exp_next = p.pc + 32'd4;
    case (p.op)
      OP_ADD:  begin exp_wd = a + b;     exp_we = 1'b1; end
      OP_SUB:  begin exp_wd = a - b;     exp_we = 1'b1; end
      OP_AND:  begin exp_wd = a & b;     exp_we = 1'b1; end
      OP_OR:   begin exp_wd = a | b;     exp_we = 1'b1; end
      OP_XOR:  begin exp_wd = a ^ b;     exp_we = 1'b1; end
      OP_ADDI: begin exp_wd = a + p.imm; exp_we = 1'b1; end
      OP_LUI:  begin exp_wd = p.imm;     exp_we = 1'b1; end
      OP_CSRRW: begin
        exp_wd  = m_csrs[p.csr_idx];
        exp_we  = 1'b1;
        exp_cwe = 1'b1;
        m_csrs[p.csr_idx] = a;
      end
      OP_ECALL: begin
        exp_next  = m_csrs[`CSR_MTVEC];
        m_csrs[`CSR_MCAUSE] = m_regs[15];
        m_csrs[`CSR_MEPC]   = p.pc;
      end
      default: ;
    endcase
    if (p.rd == 5'd0) exp_we = 1'b0;
    if (exp_we) m_regs[p.rd] = exp_wd;
    compare("pc", p.pc, retire_pc);
    compare("pc_next", exp_next, retire_pc_next);
    compare("rd", 32'(p.rd), 32'(retire_rd));
    compare("wd", exp_wd, retire_wd);
    compare("we", 32'(exp_we), 32'(retire_we));
    compare("wbu_state", 32'({exp_cwe, exp_we, 1'b1}), 32'(state_d));  // commit cycle value
    compare("ebreak", 32'(p.op == OP_EBREAK), 32'(ebreak));
  endtask

  initial begin
    errors  = 0;
    acks    = 0;
    retires = 0;
  end

  always @(posedge clk) begin
    if (rst) begin
      pend.delete();
      for (int i = 0; i < `NREG; i++) m_regs[i] = '0;
      for (int j = 0; j < `NCSR; j++) m_csrs[j] = '0;
    end else begin
      if (rst_d) begin
        compare("retire_valid after reset", 32'd0, 32'(retire_valid));
        compare("ebreak after reset", 32'd0, 32'(ebreak));
      end
      if (issue_ack && !ack_d) begin
        pend.push_back(issue_pkt);  // packet still held while req is high
        acks++;
      end
      if (retire_valid) begin
        retires++;
        retire_check();
      end
      if (done && !done_d) begin
        if (acks != retires || pend.size() != 0) begin
          errors++;
          $display("retire count %0d does not match ack count %0d", retires, acks);
        end
      end
    end
    rst_d   <= rst;
    ack_d   <= issue_ack;
    done_d  <= done;
    state_d <= wbu_state;
  end

endmodule

/* tests/core_slice_chk.sv */
module core_slice_chk (
  input logic       clk,
  input logic       rst,
  input logic       issue_req,
  input logic       issue_ack,
  input logic       wb_req,
  input logic       wb_ack,
  input logic       retire_valid,
  input logic       retire_we,
  input logic [4:0] retire_rd,
  input logic [2:0] wbu_state
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  a_issue_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(issue_ack) |-> $past(issue_req))
    else begin
      fail_count++;
      $error("issue ack rose while req was low");
    end

  a_issue_req_hold: assert property (@(posedge clk) disable iff (rst)
    $fell(issue_req) |-> issue_ack)
    else begin
      fail_count++;
      $error("issue req dropped before ack");
    end

  a_wb_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_ack) |-> wb_req)
    else begin
      fail_count++;
      $error("write-back ack rose while req was low");
    end

  a_wb_req_hold: assert property (@(posedge clk) disable iff (rst)
    wb_req && !wb_ack |=> wb_req)
    else begin
      fail_count++;
      $error("write-back req dropped before ack");
    end

  // x0 is never a write target on the trace
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    retire_valid && retire_we |-> retire_rd != 5'd0)
    else begin
      fail_count++;
      $error("retire shows a write to x0");
    end

  // a commit cycle is always followed by a retire
  a_idle_state: assert property (@(posedge clk) disable iff (rst)
    !retire_valid |-> $past(wbu_state) == 3'd0)
    else begin
      fail_count++;
      $error("wbu_state nonzero in a cycle with no retire after it");
    end

endmodule

bind core_slice_top core_slice_chk i_chk (.*);

/* logic/core_slice_top.sv */
`include "core_settings.svh"

module core_slice_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_req,
  input  core_pkg::issue_pkt_t issue_pkt,
  output logic                 issue_ack,
  output logic                 retire_valid,
  output logic [`XLEN-1:0]     retire_pc,
  output logic [`XLEN-1:0]     retire_pc_next,
  output logic [4:0]           retire_rd,
  output logic [`XLEN-1:0]     retire_wd,
  output logic                 retire_we,
  output logic [2:0]           wbu_state,
  output logic                 ebreak
);
  import core_pkg::*;

  logic             slot_valid;
  issue_pkt_t       slot_pkt;
  logic             slot_take;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [1:0]       csr_rs;
  logic [`XLEN-1:0] rsa;
  logic [`XLEN-1:0] rsb;
  logic [`XLEN-1:0] csra;
  logic             wb_req;
  wb_pkt_t          wb_pkt;
  logic             wb_ack;
  logic             commit_valid;
  wb_pkt_t          commit_pkt;
  logic             commit_take;

  pkt_slot #(.payload_t(issue_pkt_t)) i_issue_slot (
    .clk   (clk),
    .rst   (rst),
    .req   (issue_req),
    .data  (issue_pkt),
    .ack   (issue_ack),
    .valid (slot_valid),
    .pkt   (slot_pkt),
    .take  (slot_take)
  );

  exu i_exu (
    .clk        (clk),
    .rst        (rst),
    .slot_valid (slot_valid),
    .slot_pkt   (slot_pkt),
    .slot_take  (slot_take),
    .rs1        (rs1),
    .rs2        (rs2),
    .csr_rs     (csr_rs),
    .rsa        (rsa),
    .rsb        (rsb),
    .csra       (csra),
    .wb_busy    (commit_valid),  // wb slot still holds an uncommitted result
    .wb_req     (wb_req),
    .wb_pkt     (wb_pkt),
    .wb_ack     (wb_ack)
  );

  pkt_slot #(.payload_t(wb_pkt_t)) i_wb_slot (
    .clk   (clk),
    .rst   (rst),
    .req   (wb_req),
    .data  (wb_pkt),
    .ack   (wb_ack),
    .valid (commit_valid),
    .pkt   (commit_pkt),
    .take  (commit_take)
  );

  wbu i_wbu (
    .clk            (clk),
    .rst            (rst),
    .commit_valid   (commit_valid),
    .commit_pkt     (commit_pkt),
    .commit_take    (commit_take),
    .rs1            (rs1),
    .rs2            (rs2),
    .csr_rs         (csr_rs),
    .rsa            (rsa),
    .rsb            (rsb),
    .csra           (csra),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_pc_next (retire_pc_next),
    .retire_rd      (retire_rd),
    .retire_wd      (retire_wd),
    .retire_we      (retire_we),
    .wbu_state      (wbu_state),
    .ebreak         (ebreak)
  );

endmodule

/* logic/wbu.sv */
`include "core_settings.svh"

module wbu (
  input  logic              clk,
  input  logic              rst,
  input  logic              commit_valid,
  input  core_pkg::wb_pkt_t commit_pkt,
  output logic              commit_take,
  input  logic [4:0]        rs1,
  input  logic [4:0]        rs2,
  input  logic [1:0]        csr_rs,
  output logic [`XLEN-1:0]  rsa,
  output logic [`XLEN-1:0]  rsb,
  output logic [`XLEN-1:0]  csra,
  output logic              retire_valid,
  output logic [`XLEN-1:0]  retire_pc,
  output logic [`XLEN-1:0]  retire_pc_next,
  output logic [4:0]        retire_rd,
  output logic [`XLEN-1:0]  retire_wd,
  output logic              retire_we,
  output logic [2:0]        wbu_state,
  output logic              ebreak
);
  import core_pkg::*;

  logic [`XLEN-1:0] regs [`NREG];
  logic [`XLEN-1:0] csrs [`NCSR];  // mcause, mepc, mstatus, mtvec
  wb_pkt_t          ret_q;
  logic             ret_valid_q;
  logic             ebreak_q;

  // commit takes the whole cycle, slot empties right after
  assign commit_take = commit_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_valid && commit_pkt.reg_we && commit_pkt.rd != 5'd0) begin
      regs[commit_pkt.rd] <= commit_pkt.wd;  // x0 never written
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int j = 0; j < `NCSR; j++) begin
        csrs[j] <= '0;
      end
    end else if (commit_valid) begin
      if (commit_pkt.csr_we) begin
        csrs[commit_pkt.csr_idx] <= commit_pkt.csr_wd;
      end
      // trap entry, placed last so it beats a csr write to the same slot
      if (commit_pkt.ecall) begin
        csrs[`CSR_MCAUSE] <= regs[15];
        csrs[`CSR_MEPC]   <= commit_pkt.pc;
      end
    end
  end

  assign rsa  = regs[rs1];
  assign rsb  = regs[rs2];
  assign csra = csrs[csr_rs];

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid_q <= 1'b0;
      ebreak_q    <= 1'b0;
    end else begin
      ret_valid_q <= commit_valid;
      if (commit_valid) ebreak_q <= commit_pkt.ebreak;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_valid) ret_q <= commit_pkt;  // trace copy of the committed packet
  end

  assign retire_valid   = ret_valid_q;
  assign retire_pc      = ret_q.pc;
  assign retire_pc_next = ret_q.pc_next;
  assign retire_rd      = ret_q.rd;
  assign retire_wd      = ret_q.wd;
  assign retire_we      = ret_q.reg_we;
  assign ebreak         = ebreak_q;

  always_comb begin
    if (commit_valid) begin
      wbu_state = {commit_pkt.csr_we, commit_pkt.reg_we, 1'b1};
    end else begin
      wbu_state = 3'd0;
    end
  end

endmodule

/* logic/exu.sv */
`include "core_settings.svh"

module exu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 slot_valid,
  input  core_pkg::issue_pkt_t slot_pkt,
  output logic                 slot_take,
  output logic [4:0]           rs1,
  output logic [4:0]           rs2,
  output logic [1:0]           csr_rs,
  input  logic [`XLEN-1:0]     rsa,
  input  logic [`XLEN-1:0]     rsb,
  input  logic [`XLEN-1:0]     csra,
  input  logic                 wb_busy,
  output logic                 wb_req,
  output core_pkg::wb_pkt_t    wb_pkt,
  input  logic                 wb_ack
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    SND_IDLE,
    SND_REQ,
    SND_REL
  } snd_state_e;

  snd_state_e state;
  wb_pkt_t    res;
  wb_pkt_t    res_q;
  logic       launch;

  assign rs1 = slot_pkt.rs1;
  assign rs2 = slot_pkt.rs2;
  // ecall needs mtvec for the redirect
  assign csr_rs = (slot_pkt.op == OP_ECALL) ? `CSR_MTVEC : slot_pkt.csr_idx;

  always_comb begin
    res         = '0;
    res.pc      = slot_pkt.pc;
    res.pc_next = slot_pkt.pc + `XLEN'(4);
    res.rd      = slot_pkt.rd;
    res.csr_idx = slot_pkt.csr_idx;
    case (slot_pkt.op)
      OP_ADD:  begin res.wd = rsa + rsb;          res.reg_we = 1'b1; end
      OP_SUB:  begin res.wd = rsa - rsb;          res.reg_we = 1'b1; end
      OP_AND:  begin res.wd = rsa & rsb;          res.reg_we = 1'b1; end
      OP_OR:   begin res.wd = rsa | rsb;          res.reg_we = 1'b1; end
      OP_XOR:  begin res.wd = rsa ^ rsb;          res.reg_we = 1'b1; end
      OP_ADDI: begin res.wd = rsa + slot_pkt.imm; res.reg_we = 1'b1; end
      OP_LUI:  begin res.wd = slot_pkt.imm;       res.reg_we = 1'b1; end
      OP_CSRRW: begin
        res.wd     = csra;  // old value back to rd
        res.reg_we = 1'b1;
        res.csr_wd = rsa;
        res.csr_we = 1'b1;
      end
      OP_ECALL: begin
        res.pc_next = csra;
        res.ecall   = 1'b1;  // mcause/mepc written in wbu
      end
      OP_EBREAK: res.ebreak = 1'b1;
      default: ;             // unknown op retires with no writes
    endcase
    if (slot_pkt.rd == 5'd0) res.reg_we = 1'b0;
  end

  // wbu must have committed the previous result before operands are read
  assign launch = (state == SND_IDLE) && slot_valid && !wb_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SND_IDLE;
    end else begin
      case (state)
        SND_IDLE: begin
          if (launch) state <= SND_REQ;
        end
        SND_REQ: begin
          if (wb_ack) state <= SND_REL;
        end
        SND_REL: begin
          if (!wb_ack) state <= SND_IDLE;
        end
        default: state <= SND_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (launch) res_q <= res;
  end

  assign wb_req    = (state == SND_REQ);
  assign wb_pkt    = res_q;
  assign slot_take = (state == SND_REQ) && wb_ack;  // one cycle, ack rise

endmodule

/* logic/pkt_slot.sv */
module pkt_slot #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  input  payload_t data,
  output logic     ack,
  output logic     valid,
  output payload_t pkt,
  input  logic     take
);

  // ST_WAIT is the only state with ack high
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_FULL
  } slot_state_e;

  slot_state_e state;
  payload_t    buf_q;
  logic        valid_q;
  logic        capture;

  // idle always means empty
  assign capture = (state == ST_IDLE) && req;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) state <= ST_WAIT;
        end
        ST_WAIT: begin
          // sender released, keep holding if not taken yet
          if (!req) state <= (valid_q && !take) ? ST_FULL : ST_IDLE;
        end
        ST_FULL: begin
          if (take) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (capture) begin
      valid_q <= 1'b1;
    end else if (take) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) buf_q <= data;
  end

  assign ack   = (state == ST_WAIT);
  assign valid = valid_q;
  assign pkt   = buf_q;

endmodule

/* logic/core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

  typedef enum logic [3:0] {
    OP_ADD    = 4'd0,
    OP_SUB    = 4'd1,
    OP_AND    = 4'd2,
    OP_OR     = 4'd3,
    OP_XOR    = 4'd4,
    OP_ADDI   = 4'd5,
    OP_LUI    = 4'd6,
    OP_CSRRW  = 4'd7,
    OP_ECALL  = 4'd8,
    OP_EBREAK = 4'd9
  } op_e;

  // already decoded, no raw instruction bits
  typedef struct packed {
    op_e              op;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [1:0]       csr_idx;
    logic [`XLEN-1:0] imm;     // lui carries the shifted value
    logic [`XLEN-1:0] pc;
  } issue_pkt_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;
    logic [4:0]       rd;
    logic             reg_we;
    logic [`XLEN-1:0] wd;
    logic             csr_we;
    logic [1:0]       csr_idx;
    logic [`XLEN-1:0] csr_wd;
    logic             ecall;
    logic             ebreak;
  } wb_pkt_t;

endpackage

/* logic/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN        32
`define NREG        32
`define NCSR        4

// machine csr slots
`define CSR_MCAUSE  2'd0
`define CSR_MEPC    2'd1
`define CSR_MSTATUS 2'd2
`define CSR_MTVEC   2'd3

`endif
